/* design/scope_config.svh */
`ifndef SCOPE_CONFIG_SVH
`define SCOPE_CONFIG_SVH

// horizontal raster, in clock cycles
`define SCOPE_H_VISIBLE 16
`define SCOPE_H_FRONT   2
`define SCOPE_H_SYNC    3
`define SCOPE_H_BACK    3
`define SCOPE_H_WHOLE   24

// vertical raster, in lines
`define SCOPE_V_VISIBLE 12
`define SCOPE_V_FRONT   1
`define SCOPE_V_SYNC    2
`define SCOPE_V_BACK    2
`define SCOPE_V_WHOLE   17

`define SCOPE_ADC_BITS      8
`define SCOPE_COLOR_BITS    4
`define SCOPE_STARTUP_DELAY 8

`endif

/* design/scope_pkg.sv */
`include "scope_config.svh"

package scope_pkg;

  // framebuffer coordinates
  typedef logic [$clog2(`SCOPE_H_VISIBLE)-1:0] fb_x_t;
  typedef logic [$clog2(`SCOPE_V_VISIBLE)-1:0] fb_y_t;

  typedef logic [`SCOPE_ADC_BITS-1:0] adc_sample_t;

  typedef logic [`SCOPE_COLOR_BITS-1:0] color_t;

  // red in the top bits, then green, then blue
  typedef logic [3*`SCOPE_COLOR_BITS-1:0] pixel_t;

  typedef enum logic [1:0] {
    CLR_IDLE,
    CLR_RUN,
    CLR_DONE
  } clear_state_t;

endpackage

/* design/adc_sampler.sv */
`timescale 1ns/1ps
`include "scope_config.svh"

module adc_sampler
  import scope_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        enable,
  input  adc_sample_t adc_x,
  input  adc_sample_t adc_y,
  input  logic        adc_red,
  input  logic        adc_grn,
  input  logic        adc_blu,
  input  logic        pt_ready,
  output logic        pt_valid,
  output fb_x_t       pt_x,
  output fb_y_t       pt_y,
  output pixel_t      pt_color
);

  fb_x_t  in_x;
  fb_y_t  in_y;
  pixel_t in_color;
  logic   slot_load;

  // top adc bits pick the framebuffer cell
  assign in_x = adc_x[`SCOPE_ADC_BITS-1 -: $bits(fb_x_t)];
  assign in_y = adc_y[`SCOPE_ADC_BITS-1 -: $bits(fb_y_t)];

  assign in_color = {{`SCOPE_COLOR_BITS{adc_red}},
                     {`SCOPE_COLOR_BITS{adc_grn}},
                     {`SCOPE_COLOR_BITS{adc_blu}}};

  // slot free or handing its point over this cycle
  assign slot_load = enable && (!pt_valid || pt_ready);

  always_ff @(posedge clk) begin
    if (reset || !enable) begin
      pt_valid <= 1'b0;
    end else if (slot_load) begin
      // rows past the visible area are dropped here
      pt_valid <= (in_y < `SCOPE_V_VISIBLE);
    end
  end

  always_ff @(posedge clk) begin
    if (slot_load) begin
      pt_x     <= in_x;
      pt_y     <= in_y;
      pt_color <= in_color;
    end
  end

endmodule

/* design/fb_clear.sv */
`timescale 1ns/1ps
`include "scope_config.svh"

module fb_clear
  import scope_pkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  logic   clr_ready,
  output logic   clr_valid,
  output fb_x_t  clr_x,
  output fb_y_t  clr_y,
  output pixel_t clr_color,
  output logic   clr_last
);

  clear_state_t state;
  logic         xfer;
  logic         end_of_row;

  assign clr_valid  = (state == CLR_RUN);
  assign clr_color  = '0;
  assign xfer       = clr_valid && clr_ready;
  assign end_of_row = (clr_x == fb_x_t'(`SCOPE_H_VISIBLE - 1));
  assign clr_last   = clr_valid && end_of_row && (clr_y == fb_y_t'(`SCOPE_V_VISIBLE - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= CLR_IDLE;
      clr_x <= '0;
      clr_y <= '0;
    end else begin
      case (state)
        CLR_IDLE: state <= CLR_RUN;
        CLR_RUN: begin
          if (xfer) begin
            if (clr_last) begin
              state <= CLR_DONE;
            end else if (end_of_row) begin
              clr_x <= '0;
              clr_y <= clr_y + 1'b1;
            end else begin
              clr_x <= clr_x + 1'b1;
            end
          end
        end
        // sweep finished, nothing more to offer
        default: state <= CLR_DONE;
      endcase
    end
  end

endmodule

/* design/startup_ctrl.sv */
`timescale 1ns/1ps
`include "scope_config.svh"

module startup_ctrl
  import scope_pkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  logic   clr_valid,
  input  fb_x_t  clr_x,
  input  fb_y_t  clr_y,
  input  pixel_t clr_color,
  input  logic   clr_last,
  output logic   clr_ready,
  input  logic   pt_valid,
  input  fb_x_t  pt_x,
  input  fb_y_t  pt_y,
  input  pixel_t pt_color,
  output logic   pt_ready,
  input  logic   wr_ready,
  output logic   wr_valid,
  output fb_x_t  wr_x,
  output fb_y_t  wr_y,
  output pixel_t wr_color,
  output logic   adc_active,
  output logic   vga_enable
);

  logic                            last_xfer;
  logic [`SCOPE_STARTUP_DELAY-1:0] last_dly;

  assign last_xfer = clr_valid && clr_ready && clr_last;

  // let the final clear write settle before handing over
  always_ff @(posedge clk) begin
    if (reset) begin
      last_dly <= '0;
    end else begin
      last_dly <= {last_dly[`SCOPE_STARTUP_DELAY-2:0], last_xfer};
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      adc_active <= 1'b0;
      vga_enable <= 1'b0;
    end else begin
      if (last_dly[`SCOPE_STARTUP_DELAY-1]) begin
        adc_active <= 1'b1;
        vga_enable <= 1'b1;
      end
    end
  end

  // source mux, the idle source sees ready low
  assign wr_valid  = adc_active ? pt_valid : clr_valid;
  assign wr_x      = adc_active ? pt_x : clr_x;
  assign wr_y      = adc_active ? pt_y : clr_y;
  assign wr_color  = adc_active ? pt_color : clr_color;
  assign pt_ready  = adc_active && wr_ready;
  assign clr_ready = !adc_active && wr_ready;

endmodule

/* design/fb_fade_ram.sv */
`timescale 1ns/1ps
`include "scope_config.svh"

module fb_fade_ram
  import scope_pkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  logic   vga_enable,
  input  logic   wr_valid,
  input  fb_x_t  wr_x,
  input  fb_y_t  wr_y,
  input  pixel_t wr_color,
  output logic   wr_ready,
  input  fb_x_t  scan_x,
  input  fb_y_t  scan_y,
  input  logic   scan_visible,
  input  logic   hsync_raw,
  input  logic   vsync_raw,
  output color_t vga_red,
  output color_t vga_grn,
  output color_t vga_blu,
  output logic   vga_hsync,
  output logic   vga_vsync
);

  localparam int FB_DEPTH  = `SCOPE_H_VISIBLE * `SCOPE_V_VISIBLE;
  localparam int ADDR_BITS = $clog2(FB_DEPTH);

  typedef logic [ADDR_BITS-1:0] fb_addr_t;

  pixel_t   mem [FB_DEPTH];
  pixel_t   rd_pix;
  fb_addr_t rd_addr;
  logic     rd_visible;
  logic     fade_we;
  pixel_t   fade_pix;

  function automatic fb_addr_t cell_addr(fb_x_t x, fb_y_t y);
    return fb_addr_t'(y * `SCOPE_H_VISIBLE + x);
  endfunction

  // one step dimmer, stops at black
  function automatic color_t fade_channel(color_t c);
    return (c == '0) ? c : c - 1'b1;
  endfunction

  // scan read, one cycle of latency
  always_ff @(posedge clk) begin
    rd_pix  <= mem[cell_addr(scan_x, scan_y)];
    rd_addr <= cell_addr(scan_x, scan_y);
  end

  // syncs ride along with the pixel
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_visible <= 1'b0;
      vga_hsync  <= 1'b1;
      vga_vsync  <= 1'b1;
    end else begin
      rd_visible <= scan_visible;
      vga_hsync  <= hsync_raw;
      vga_vsync  <= vsync_raw;
    end
  end

  assign vga_red = rd_visible ? rd_pix[3*`SCOPE_COLOR_BITS-1 -: `SCOPE_COLOR_BITS] : '0;
  assign vga_grn = rd_visible ? rd_pix[2*`SCOPE_COLOR_BITS-1 -: `SCOPE_COLOR_BITS] : '0;
  assign vga_blu = rd_visible ? rd_pix[`SCOPE_COLOR_BITS-1:0] : '0;

  assign fade_pix = {fade_channel(vga_red), fade_channel(vga_grn), fade_channel(vga_blu)};

  // writeback owns the write port on shown pixels
  assign fade_we  = rd_visible && vga_enable;
  assign wr_ready = !fade_we;

  always_ff @(posedge clk) begin
    if (fade_we) begin
      mem[rd_addr] <= fade_pix;
    end else if (wr_valid) begin
      mem[cell_addr(wr_x, wr_y)] <= wr_color;
    end
  end

endmodule

/* design/vga_timing.sv */
`timescale 1ns/1ps
`include "scope_config.svh"

module vga_timing
  import scope_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  logic  vga_enable,
  output fb_x_t scan_x,
  output fb_y_t scan_y,
  output logic  scan_visible,
  output logic  hsync_raw,
  output logic  vsync_raw
);

  localparam int H_SYNC_START = `SCOPE_H_VISIBLE + `SCOPE_H_FRONT;
  localparam int H_SYNC_END   = H_SYNC_START + `SCOPE_H_SYNC;
  localparam int V_SYNC_START = `SCOPE_V_VISIBLE + `SCOPE_V_FRONT;
  localparam int V_SYNC_END   = V_SYNC_START + `SCOPE_V_SYNC;

  logic [$clog2(`SCOPE_H_WHOLE)-1:0] h_count;
  logic [$clog2(`SCOPE_V_WHOLE)-1:0] v_count;
  logic                              h_sync_on;
  logic                              v_sync_on;

  always_ff @(posedge clk) begin
    if (reset || !vga_enable) begin
      h_count <= '0;
      v_count <= '0;
    end else if (h_count == `SCOPE_H_WHOLE - 1) begin
      h_count <= '0;
      // back porch ends the frame
      if (v_count == `SCOPE_V_WHOLE - 1) begin
        v_count <= '0;
      end else begin
        v_count <= v_count + 1'b1;
      end
    end else begin
      h_count <= h_count + 1'b1;
    end
  end

  assign scan_x = fb_x_t'(h_count);
  assign scan_y = fb_y_t'(v_count);

  assign scan_visible = vga_enable && (h_count < `SCOPE_H_VISIBLE) &&
                        (v_count < `SCOPE_V_VISIBLE);

  assign h_sync_on = (h_count >= H_SYNC_START) && (h_count < H_SYNC_END);
  assign v_sync_on = (v_count >= V_SYNC_START) && (v_count < V_SYNC_END);

  // syncs idle high until the raster runs
  assign hsync_raw = !(vga_enable && h_sync_on);
  assign vsync_raw = !(vga_enable && v_sync_on);

endmodule

/* design/scope_top.sv */
`timescale 1ns/1ps

module scope_top
  import scope_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  adc_sample_t adc_x,
  input  adc_sample_t adc_y,
  input  logic        adc_red,
  input  logic        adc_grn,
  input  logic        adc_blu,
  output color_t      vga_red,
  output color_t      vga_grn,
  output color_t      vga_blu,
  output logic        vga_hsync,
  output logic        vga_vsync
);

  // point source
  logic   pt_valid;
  logic   pt_ready;
  fb_x_t  pt_x;
  fb_y_t  pt_y;
  pixel_t pt_color;

  // clear source
  logic   clr_valid;
  logic   clr_ready;
  fb_x_t  clr_x;
  fb_y_t  clr_y;
  pixel_t clr_color;
  logic   clr_last;

  // framebuffer write port
  logic   wr_valid;
  logic   wr_ready;
  fb_x_t  wr_x;
  fb_y_t  wr_y;
  pixel_t wr_color;

  logic   adc_active;
  logic   vga_enable;

  // raster scan
  fb_x_t  scan_x;
  fb_y_t  scan_y;
  logic   scan_visible;
  logic   hsync_raw;
  logic   vsync_raw;

  adc_sampler u_adc_sampler (
    .clk(clk), .reset(reset), .enable(adc_active),
    .adc_x(adc_x), .adc_y(adc_y),
    .adc_red(adc_red), .adc_grn(adc_grn), .adc_blu(adc_blu),
    .pt_ready(pt_ready), .pt_valid(pt_valid),
    .pt_x(pt_x), .pt_y(pt_y), .pt_color(pt_color)
  );

  fb_clear u_fb_clear (
    .clk(clk), .reset(reset), .clr_ready(clr_ready), .clr_valid(clr_valid),
    .clr_x(clr_x), .clr_y(clr_y), .clr_color(clr_color), .clr_last(clr_last)
  );

  startup_ctrl u_startup_ctrl (
    .clk(clk), .reset(reset),
    .clr_valid(clr_valid), .clr_x(clr_x), .clr_y(clr_y),
    .clr_color(clr_color), .clr_last(clr_last), .clr_ready(clr_ready),
    .pt_valid(pt_valid), .pt_x(pt_x), .pt_y(pt_y),
    .pt_color(pt_color), .pt_ready(pt_ready),
    .wr_ready(wr_ready), .wr_valid(wr_valid), .wr_x(wr_x), .wr_y(wr_y),
    .wr_color(wr_color), .adc_active(adc_active), .vga_enable(vga_enable)
  );

  fb_fade_ram u_fb_fade_ram (
    .clk(clk), .reset(reset), .vga_enable(vga_enable),
    .wr_valid(wr_valid), .wr_x(wr_x), .wr_y(wr_y), .wr_color(wr_color),
    .wr_ready(wr_ready),
    .scan_x(scan_x), .scan_y(scan_y), .scan_visible(scan_visible),
    .hsync_raw(hsync_raw), .vsync_raw(vsync_raw),
    .vga_red(vga_red), .vga_grn(vga_grn), .vga_blu(vga_blu),
    .vga_hsync(vga_hsync), .vga_vsync(vga_vsync)
  );

  vga_timing u_vga_timing (
    .clk(clk), .reset(reset), .vga_enable(vga_enable),
    .scan_x(scan_x), .scan_y(scan_y), .scan_visible(scan_visible),
    .hsync_raw(hsync_raw), .vsync_raw(vsync_raw)
  );

endmodule

/* verif/scope_tb.sv */
`timescale 1ns/1ps
`include "scope_config.svh"

module scope_tb
  import scope_pkg::*;
();

  localparam int C            = `SCOPE_COLOR_BITS;
  localparam int H_VISIBLE    = `SCOPE_H_VISIBLE;
  localparam int V_VISIBLE    = `SCOPE_V_VISIBLE;
  localparam int H_WHOLE      = `SCOPE_H_WHOLE;
  localparam int V_WHOLE      = `SCOPE_V_WHOLE;
  localparam int H_SYNC_START = `SCOPE_H_VISIBLE + `SCOPE_H_FRONT;
  localparam int V_SYNC_START = `SCOPE_V_VISIBLE + `SCOPE_V_FRONT;
  localparam int FRAME_CYCLES = H_WHOLE * V_WHOLE;
  localparam int FB_CELLS     = H_VISIBLE * V_VISIBLE;

  logic        clk;
  logic        reset;
  adc_sample_t adc_x;
  adc_sample_t adc_y;
  logic        adc_red;
  logic        adc_grn;
  logic        adc_blu;
  color_t      vga_red;
  color_t      vga_grn;
  color_t      vga_blu;
  logic        vga_hsync;
  logic        vga_vsync;

  integer seed = 32'h71d0;
  int     errors = 0;
  int     tests_run = 0;
  int     tests_failed = 0;
  int     err_base = 0;

  // expected framebuffer contents as the raster fades them
  pixel_t exp_mem [FB_CELLS];
  int     cyc = 0;
  int     col = 0;
  int     line = 0;
  logic   line_known = 1'b0;
  logic   prev_hs = 1'b1;
  logic   prev_vs = 1'b1;
  int     hfalls = 0;
  int     vfalls = 0;
  int     last_hfall = 0;
  int     last_vfall = 0;
  int     vs_low = 0;
  int     frame_count = 0;
  int     vis_count = 0;
  int     last_frame_vis = 0;
  int     spot_addr = -1;
  pixel_t spot_seen = '0;

  scope_top dut (
    .clk(clk), .reset(reset), .adc_x(adc_x), .adc_y(adc_y),
    .adc_red(adc_red), .adc_grn(adc_grn), .adc_blu(adc_blu),
    .vga_red(vga_red), .vga_grn(vga_grn), .vga_blu(vga_blu),
    .vga_hsync(vga_hsync), .vga_vsync(vga_vsync)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic color_t channel(pixel_t p, int idx);
    return p[idx*C +: C];
  endfunction

  function automatic color_t dim(color_t c);
    return (c == 0) ? c : color_t'(c - 1);
  endfunction

  task automatic flag_mismatch(string name, int want, int got);
    $display("FAILED %0t ns %s expected %0h got %0h", $time, name, want, got);
    errors++;
  endtask

  task automatic report_problem(string msg);
    $display("error at %0t ns: %s", $time, msg);
    errors++;
  endtask

  task automatic abort_run(string msg);
    $display("timeout at %0t ns: %s", $time, msg);
    $display("sim failed");
    $finish;
  endtask

  task automatic end_test(string name);
    tests_run++;
    if (errors == err_base) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, errors - err_base);
    end
    err_base = errors;
  endtask

  task automatic wait_vsync_fall();
    int start;
    int n;
    start = frame_count;
    n = 0;
    while (frame_count == start && n < FRAME_CYCLES + 2 * H_WHOLE) begin
      @(posedge clk);
      n++;
    end
    if (frame_count == start) abort_run("vsync falling edge did not arrive");
  endtask

  // sync pulse width straight from the DUT pins
  hsync_width: assert property (@(negedge clk) disable iff (reset)
    $fell(vga_hsync) |-> !vga_hsync ##1 !vga_hsync ##1 !vga_hsync ##1 vga_hsync)
    else report_problem("hsync low pulse is not 3 cycles long");

  sync_black: assert property (@(negedge clk) disable iff (reset)
    !(vga_hsync && vga_vsync) |-> {vga_red, vga_grn, vga_blu} == '0)
    else report_problem("colour output is non-zero during a sync pulse");

  // raster position from the sync edges and a check of every output pixel
  always @(negedge clk) begin : raster_monitor
    pixel_t want;
    int     addr;
    if (!reset) begin
      cyc++;
      if (col == H_WHOLE - 1) begin
        col = 0;
        line = (line == V_WHOLE - 1) ? 0 : line + 1;
      end else begin
        col++;
      end
      if (prev_hs && !vga_hsync) begin
        if (hfalls > 0)
          assert (cyc - last_hfall == H_WHOLE)
          else flag_mismatch("vga_hsync fall spacing", H_WHOLE, cyc - last_hfall);
        hfalls++;
        last_hfall = cyc;
        col = H_SYNC_START;
      end
      if (!vga_vsync) vs_low++;
      if (!prev_vs && vga_vsync) begin
        assert (vs_low == `SCOPE_V_SYNC * H_WHOLE)
        else flag_mismatch("vga_vsync low cycles", `SCOPE_V_SYNC * H_WHOLE, vs_low);
        vs_low = 0;
      end
      if (prev_vs && !vga_vsync) begin
        if (vfalls > 0)
          assert (cyc - last_vfall == FRAME_CYCLES)
          else flag_mismatch("vga_vsync fall spacing", FRAME_CYCLES, cyc - last_vfall);
        vfalls++;
        last_vfall = cyc;
        line = V_SYNC_START;
        col = 0;
        line_known = 1'b1;
        last_frame_vis = vis_count;
        vis_count = 0;
        frame_count++;
      end
      prev_hs = vga_hsync;
      prev_vs = vga_vsync;
      if (line_known && col < H_VISIBLE && line < V_VISIBLE) begin
        addr = line * H_VISIBLE + col;
        want = exp_mem[addr];
        assert ({vga_red, vga_grn, vga_blu} == want)
        else flag_mismatch("vga pixel", want, {vga_red, vga_grn, vga_blu});
        if (addr == spot_addr) spot_seen = {vga_red, vga_grn, vga_blu};
        exp_mem[addr] = {dim(channel(want, 2)), dim(channel(want, 1)), dim(channel(want, 0))};
        vis_count++;
      end
    end
  end

  // point driven during vertical blank before y goes off screen
  task automatic plot_point(input logic [2:0] rgb);
    int    r;
    fb_x_t px;
    fb_y_t py;
    r = $random(seed);
    px = r[3:0];
    py = fb_y_t'((r & 32'h7fff_ffff) % V_VISIBLE);
    wait_vsync_fall();
    spot_addr = py * H_VISIBLE + px;
    repeat (4) begin
      @(negedge clk);
      adc_x = {px, r[11:8]};
      adc_y = {py, r[15:12]};
      adc_red = rgb[2];
      adc_grn = rgb[1];
      adc_blu = rgb[0];
    end
    @(negedge clk);
    adc_y = 8'hf0;
    {adc_red, adc_grn, adc_blu} = 3'b000;
    exp_mem[spot_addr] = {{C{rgb[2]}}, {C{rgb[1]}}, {C{rgb[0]}}};
  endtask

  task automatic check_fade(input logic [2:0] rgb);
    color_t lvl;
    pixel_t want;
    for (int k = 0; k <= 16; k++) begin
      wait_vsync_fall();
      lvl = (k < 15) ? color_t'(15 - k) : color_t'(0);
      want = {rgb[2] ? lvl : color_t'(0), rgb[1] ? lvl : color_t'(0), rgb[0] ? lvl : color_t'(0)};
      assert (spot_seen == want) else flag_mismatch("plotted pixel", want, spot_seen);
    end
  endtask

  initial begin : stimulus
    int r;
    int start;
    int n;
    reset = 1'b1;
    adc_x = '0;
    adc_y = 8'hf0;
    {adc_red, adc_grn, adc_blu} = 3'b000;
    for (int i = 0; i < FB_CELLS; i++) exp_mem[i] = '0;
    repeat (5) @(negedge clk);
    reset = 1'b0;

    repeat (200) begin
      @(negedge clk);
      assert (vga_hsync && vga_vsync) else report_problem("a sync went low during the clear");
      assert ({vga_red, vga_grn, vga_blu} == '0) else report_problem("colour during the clear");
    end
    n = 0;
    while (hfalls == 0 && n < 100) begin
      @(posedge clk);
      n++;
    end
    if (hfalls == 0) abort_run("no hsync falling edge after the clear");
    end_test("reset and startup");

    wait_vsync_fall();
    start = hfalls;
    wait_vsync_fall();
    assert (hfalls - start == V_WHOLE)
    else flag_mismatch("vga_hsync falls per frame", V_WHOLE, hfalls - start);
    end_test("sync timing");

    wait_vsync_fall();
    assert (last_frame_vis == FB_CELLS)
    else flag_mismatch("visible pixels per frame", FB_CELLS, last_frame_vis);
    end_test("cleared frame");

    plot_point(3'b100);
    check_fade(3'b100);
    end_test("point plot and fade");

    wait_vsync_fall();
    start = frame_count;
    n = 0;
    while (frame_count == start && n < FRAME_CYCLES + 2 * H_WHOLE) begin
      @(negedge clk);
      r = $random(seed);
      adc_x = r[7:0];
      adc_y = {2'b11, r[9:8], r[13:10]};
      {adc_red, adc_grn, adc_blu} = 3'b111;
      @(posedge clk);
      n++;
    end
    if (frame_count == start) abort_run("frame with off-screen points did not end");
    @(negedge clk);
    adc_y = 8'hf0;
    {adc_red, adc_grn, adc_blu} = 3'b000;
    wait_vsync_fall();
    assert (last_frame_vis == FB_CELLS)
    else flag_mismatch("visible pixels per frame", FB_CELLS, last_frame_vis);
    end_test("out-of-range drop");

    plot_point(3'b010);
    check_fade(3'b010);
    plot_point(3'b101);
    check_fade(3'b101);
    end_test("colour channels");

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* tb.f */
+incdir+design
design/scope_pkg.sv
design/adc_sampler.sv
design/fb_clear.sv
design/startup_ctrl.sv
design/fb_fade_ram.sv
design/vga_timing.sv
design/scope_top.sv
verif/scope_tb.sv
